/* dv/rv_core_checker.sv */
// rv_core_checker: watches putch strobes, data-bus stores and held requests of the core
`timescale 1ns/1ns
`default_nettype none

module rv_core_checker (
  input  wire logic                     i_clk,
  input  wire logic                     i_rst,
  input  wire logic                     i_ibus_req,
  input  wire logic [rv_pkg::XLEN-1:0]  i_ibus_addr,
  input  wire logic                     i_ibus_ack,
  input  wire logic                     i_dbus_req,
  input  wire logic                     i_dbus_we,
  input  wire logic [rv_pkg::XLEN-1:0]  i_dbus_addr,
  input  wire logic [rv_pkg::XLEN-1:0]  i_dbus_wdata,
  input  wire logic                     i_dbus_ack,
  input  wire logic                     i_putch_valid,
  input  wire logic [7:0]               i_putch_char,
  output logic                          o_done,
  output int                            o_pass_cnt,
  output int                            o_fail_cnt
);

  logic [63:0]             stim [0:127];
  int                      char_base;
  int                      store_base;
  int                      char_idx;
  int                      store_idx;
  int                      hold_errs;
  int                      rst_edges;
  logic                    rst_bad;
  logic                    rst_scored;
  logic                    fetch_seen;
  logic                    ireq_q;
  logic                    iack_q;
  logic [rv_pkg::XLEN-1:0] iaddr_q;
  logic                    dreq_q;
  logic                    dack_q;
  logic                    dwe_q;
  logic [rv_pkg::XLEN-1:0] daddr_q;
  logic [rv_pkg::XLEN-1:0] dwdata_q;

  task automatic score_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    if (exp === act) begin
      o_pass_cnt++;
      $display("PASSED %s 0x%0h", name, act);
    end else begin
      o_fail_cnt++;
      $display("FAILED %s expected 0x%0h actual 0x%0h", name, exp, act);
    end
  endtask

  task automatic note_failure(input string msg);
    o_fail_cnt++;
    $display("%s", msg);
  endtask

  initial begin
    $readmemh("dv/rv_core_stimulus.mem", stim);
    char_base  = 4 + int'(stim[0]);
    store_base = char_base + int'(stim[2]);
    char_idx   = 0;
    store_idx  = 0;
    hold_errs  = 0;
    rst_edges  = 0;
    rst_bad    = 1'b0;
    rst_scored = 1'b0;
    fetch_seen = 1'b0;
    ireq_q     = 1'b0;
    dreq_q     = 1'b0;
    o_done     = 1'b0;
    o_pass_cnt = 0;
    o_fail_cnt = 0;
  end

  ////////////////////////////////////////////////////////////////////
  // sampled at the rising edge like the core

  always @(posedge i_clk) begin
    if (i_rst) begin
      rst_edges++;
      // outputs are unknown until the first reset edge
      if (rst_edges > 1 && (i_ibus_req !== 1'b0 || i_dbus_req !== 1'b0 ||
                            i_putch_valid !== 1'b0)) begin
        rst_bad = 1'b1;
      end
    end else begin
      if (!rst_scored) begin
        rst_scored = 1'b1;
        if (rst_bad) begin
          note_failure("reset_quiet: a bus request or putch strobe was high during reset");
        end else begin
          o_pass_cnt++;
          $display("PASSED reset_quiet");
        end
      end
      if (!fetch_seen && i_ibus_req === 1'b1) begin
        fetch_seen = 1'b1;
        score_value("reset_first_fetch", 64'h0, i_ibus_addr);
      end
      if (i_ibus_req && ireq_q && !iack_q && i_ibus_addr !== iaddr_q) begin
        hold_errs++;
        $display("instruction bus address changed while its request waited for ack");
      end
      if (i_dbus_req && dreq_q && !dack_q &&
          (i_dbus_addr !== daddr_q || i_dbus_wdata !== dwdata_q || i_dbus_we !== dwe_q)) begin
        hold_errs++;
        $display("data bus address or write data changed while its request waited for ack");
      end
      if (i_putch_valid) begin
        if (char_idx < int'(stim[2])) begin
          score_value($sformatf("putch[%0d]", char_idx),
                      {56'h0, stim[char_base + char_idx][7:0]}, {56'h0, i_putch_char});
          char_idx++;
        end else begin
          note_failure($sformatf("an unexpected extra character 0x%0h was printed",
                                 i_putch_char));
        end
      end
      if (i_dbus_req && i_dbus_ack && i_dbus_we) begin
        if (store_idx < int'(stim[3])) begin
          score_value($sformatf("store[%0d].addr", store_idx),
                      stim[store_base + 2 * store_idx], i_dbus_addr);
          score_value($sformatf("store[%0d].data", store_idx),
                      stim[store_base + 2 * store_idx + 1], i_dbus_wdata);
          store_idx++;
        end else begin
          note_failure($sformatf("an unexpected extra store to 0x%0h was seen", i_dbus_addr));
        end
      end
      if (!o_done && fetch_seen && char_idx == int'(stim[2]) &&
          store_idx == int'(stim[3])) begin
        o_done = 1'b1;
        if (hold_errs == 0) begin
          o_pass_cnt++;
          $display("PASSED bus_hold");
        end else begin
          note_failure($sformatf("bus_hold: %0d held requests changed before ack",
                                 hold_errs));
        end
      end
    end
    ireq_q   = i_ibus_req;
    iack_q   = i_ibus_ack;
    iaddr_q  = i_ibus_addr;
    dreq_q   = i_dbus_req;
    dack_q   = i_dbus_ack;
    dwe_q    = i_dbus_we;
    daddr_q  = i_dbus_addr;
    dwdata_q = i_dbus_wdata;
  end

endmodule

`default_nettype wire

/* dv/rv_core_stimulus.mem */
// header: program words, dynamic instruction count, expected characters, expected stores
// then program words from address 0, expected characters, expected store address/data pairs
31 2b 0a 05
// program, four words per line
000010b7 04808093 0ff00113 0020f533
0000007b 02100193 00356533 0000007b
00c00213 00454533 0000007b 40350533
0000007b 10000293 00108333 0062b423
403003b3 0072b823 0082b403 fc040413
0082bc23 00247533 0000007b 03100513
00310463 0000007b 03200513 00311663
05800513 0000007b 0000007b 0ff00493
03300513 00248663 05900513 0000007b
0000007b 03400513 00249463 0000007b
00c000ef 05a00513 0000007b 0212b023
05510013 0202b423 00a00513 0000007b
0000006f
// expected characters: H i e D P 1 2 3 4 newline
48 69 65 44 50 31 32 33 34 0a
// expected stores, address then data
108 2090
110 ffffffffffffffdf
118 2050
120 a4
128 0

/* dv/tb_rv_core.sv */
// tb_rv_core: clock, reset, program and data memory models with random ack delays
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;

  logic                    clk;
  logic                    rst;
  logic                    ibus_req;
  logic [rv_pkg::XLEN-1:0] ibus_addr;
  logic                    ibus_ack;
  logic [rv_pkg::ILEN-1:0] ibus_rdata;
  logic                    dbus_req;
  logic                    dbus_we;
  logic [rv_pkg::XLEN-1:0] dbus_addr;
  logic [rv_pkg::XLEN-1:0] dbus_wdata;
  logic                    dbus_ack;
  logic [rv_pkg::XLEN-1:0] dbus_rdata;
  logic                    putch_valid;
  logic [7:0]              putch_char;
  logic                    done;
  int                      pass_cnt;
  int                      fail_cnt;

  logic [63:0] stim [0:127];
  logic [63:0] dmem [0:63];
  logic [15:0] lfsr_state;
  logic        ibus_busy;
  int          ibus_wait;
  logic        dbus_busy;
  int          dbus_wait;
  int          cycles;
  int          limit;

  rv_core UUT (
    .i_clk         (clk),
    .i_rst         (rst),
    .o_ibus_req    (ibus_req),
    .o_ibus_addr   (ibus_addr),
    .i_ibus_ack    (ibus_ack),
    .i_ibus_rdata  (ibus_rdata),
    .o_dbus_req    (dbus_req),
    .o_dbus_we     (dbus_we),
    .o_dbus_addr   (dbus_addr),
    .o_dbus_wdata  (dbus_wdata),
    .i_dbus_ack    (dbus_ack),
    .i_dbus_rdata  (dbus_rdata),
    .o_putch_valid (putch_valid),
    .o_putch_char  (putch_char)
  );

  rv_core_checker u_checker (
    .i_clk         (clk),
    .i_rst         (rst),
    .i_ibus_req    (ibus_req),
    .i_ibus_addr   (ibus_addr),
    .i_ibus_ack    (ibus_ack),
    .i_dbus_req    (dbus_req),
    .i_dbus_we     (dbus_we),
    .i_dbus_addr   (dbus_addr),
    .i_dbus_wdata  (dbus_wdata),
    .i_dbus_ack    (dbus_ack),
    .i_putch_valid (putch_valid),
    .i_putch_char  (putch_char),
    .o_done        (done),
    .o_pass_cnt    (pass_cnt),
    .o_fail_cnt    (fail_cnt)
  );

  // galois form of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // three bits give 0 to 7 cycles
  task automatic draw_delay(output int d);
    d = 0;
    for (int b = 0; b < 3; b++) begin
      d = (d << 1) | lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // past the program an addi to x0 whose immediate folds the whole address
  function automatic logic [31:0] fetch_word(input logic [63:0] addr);
    logic [63:0] idx;
    logic [11:0] tag;
    idx = addr >> 2;
    tag = '0;
    for (int k = 0; k < 64; k += 12) begin
      tag ^= 12'(addr >> k);
    end
    if (idx < stim[0]) begin
      fetch_word = stim[4 + idx][31:0];
    end else begin
      fetch_word = {tag, 20'h00013};
    end
  endfunction

  function automatic logic [63:0] fill_word(input int k);
    logic [31:0] a;
    a = k * 8;
    fill_word = {32'hda7a_0000 ^ a, ~a};
  endfunction

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////
  // bus models driven on the falling edge

  always @(negedge clk) begin
    if (ibus_ack) begin
      ibus_ack = 1'b0;
    end else if (ibus_req) begin
      if (!ibus_busy) begin
        ibus_busy = 1'b1;
        draw_delay(ibus_wait);
      end
      if (ibus_wait == 0) begin
        ibus_ack   = 1'b1;
        ibus_rdata = fetch_word(ibus_addr);
        ibus_busy  = 1'b0;
      end else begin
        ibus_wait--;
      end
    end
    if (dbus_ack) begin
      dbus_ack = 1'b0;
    end else if (dbus_req) begin
      if (!dbus_busy) begin
        dbus_busy = 1'b1;
        draw_delay(dbus_wait);
      end
      if (dbus_wait == 0) begin
        dbus_ack  = 1'b1;
        dbus_busy = 1'b0;
        if (dbus_we) begin
          dmem[dbus_addr[8:3]] = dbus_wdata;
        end else begin
          dbus_rdata = dmem[dbus_addr[8:3]];
        end
      end else begin
        dbus_wait--;
      end
    end
  end

  initial begin
    rst        = 1'b1;
    ibus_ack   = 1'b0;
    ibus_rdata = '0;
    dbus_ack   = 1'b0;
    dbus_rdata = '0;
    ibus_busy  = 1'b0;
    ibus_wait  = 0;
    dbus_busy  = 1'b0;
    dbus_wait  = 0;
    lfsr_state = 16'd99;
    cycles     = 0;
    $readmemh("dv/rv_core_stimulus.mem", stim);
    for (int k = 0; k < 64; k++) begin
      dmem[k] = fill_word(k);
    end
    // random acks keep the average well under 20 cycles per instruction
    limit = int'(stim[1]) * 20 + 100;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (!done && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    @(negedge clk);
    if (!done) begin
      $display("run timed out after %0d cycles before all expected events were seen", cycles);
    end
    $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
    if (done && fail_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
// decode_stage: splits the instruction word, reads registers and builds operands
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
  input  wire logic                          i_clk,
  input  wire logic                          i_rst,
  input  wire logic                          i_fetch_req,
  input  wire rv_pkg::fetch_pkt_t            i_fetch_pkt,
  output logic                               o_fetch_ack,
  output logic [rv_pkg::REG_IDX_W-1:0]       o_rs1_idx,
  output logic [rv_pkg::REG_IDX_W-1:0]       o_rs2_idx,
  input  wire logic [rv_pkg::XLEN-1:0]       i_rs1_data,
  input  wire logic [rv_pkg::XLEN-1:0]       i_rs2_data,
  output logic                               o_dec_req,
  output rv_pkg::dec_pkt_t                   o_dec_pkt,
  input  wire logic                          i_dec_ack
);

  rv_pkg::fetch_pkt_t      pkt_q;
  rv_pkg::inst_u           inst;
  rv_pkg::dec_pkt_t        dec_next;
  logic [rv_pkg::XLEN-1:0] imm;
  logic                    use_imm;
  logic                    is_putch;

  assign inst     = pkt_q.inst;
  assign is_putch = (inst == rv_pkg::PUTCH_INST);

  // putch reads a0 through the rs1 port
  assign o_rs1_idx = is_putch ? rv_pkg::PUTCH_REG : inst.r.rs1;
  assign o_rs2_idx = inst.r.rs2;

  // immediate from the format view the opcode picks
  always_comb begin
    case (inst.r.opcode)
      rv_pkg::OPC_OP_IMM, rv_pkg::OPC_LOAD:
        imm = {{52{inst.i.imm[11]}}, inst.i.imm};
      rv_pkg::OPC_STORE:
        imm = {{52{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
      rv_pkg::OPC_BRANCH:
        imm = {{51{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
               inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
      rv_pkg::OPC_LUI:
        imm = {{32{inst.u.imm[19]}}, inst.u.imm, 12'b0};
      rv_pkg::OPC_JAL:
        imm = {{43{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
               inst.j.imm_11, inst.j.imm_10_1, 1'b0};
      default:
        imm = '0;
    endcase
  end

  always_comb begin
    dec_next          = '0;
    use_imm           = 1'b0;
    dec_next.alu_op   = rv_pkg::ALU_ADD;
    dec_next.is_putch = is_putch;
    case (inst.r.opcode)
      rv_pkg::OPC_OP: begin
        dec_next.rd_wen = 1'b1;
        case (inst.r.funct3)
          3'b000:  dec_next.alu_op = inst.r.funct7[5] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
          3'b100:  dec_next.alu_op = rv_pkg::ALU_XOR;
          3'b110:  dec_next.alu_op = rv_pkg::ALU_OR;
          3'b111:  dec_next.alu_op = rv_pkg::ALU_AND;
          default: dec_next.rd_wen = 1'b0;
        endcase
      end
      // only ADDI of the immediate group
      rv_pkg::OPC_OP_IMM: begin
        dec_next.rd_wen = (inst.i.funct3 == 3'b000);
        use_imm         = 1'b1;
      end
      rv_pkg::OPC_LUI: begin
        dec_next.alu_op = rv_pkg::ALU_PASS;
        dec_next.rd_wen = 1'b1;
        use_imm         = 1'b1;
      end
      rv_pkg::OPC_LOAD: begin
        dec_next.is_load = (inst.i.funct3 == 3'b011);
        dec_next.rd_wen  = dec_next.is_load;
      end
      rv_pkg::OPC_STORE: begin
        dec_next.is_store = (inst.s.funct3 == 3'b011);
      end
      rv_pkg::OPC_BRANCH: begin
        dec_next.is_beq = (inst.b.funct3 == 3'b000);
        dec_next.is_bne = (inst.b.funct3 == 3'b001);
      end
      rv_pkg::OPC_JAL: begin
        dec_next.is_jal = 1'b1;
        dec_next.rd_wen = 1'b1;
      end
      default: ;
    endcase
    dec_next.pc      = pkt_q.pc;
    dec_next.rd      = inst.r.rd;
    dec_next.imm     = imm;
    dec_next.op1     = i_rs1_data;
    dec_next.op2     = use_imm ? imm : i_rs2_data;
    dec_next.st_data = i_rs2_data;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_fetch_ack <= 1'b0;
      o_dec_req   <= 1'b0;
    end else begin
      o_fetch_ack <= i_fetch_req && !o_fetch_ack && !o_dec_req;
      if (o_fetch_ack) begin
        o_dec_req <= 1'b1;
      end else if (i_dec_ack) begin
        o_dec_req <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fetch_req && !o_fetch_ack && !o_dec_req) begin
      pkt_q <= i_fetch_pkt;
    end
    if (o_fetch_ack) begin
      o_dec_pkt <= dec_next;
    end
  end

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
// execute_stage: alu, branch and jump resolution, next pc and memory address
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
  input  wire logic              i_clk,
  input  wire logic              i_rst,
  input  wire logic              i_dec_req,
  input  wire rv_pkg::dec_pkt_t  i_dec_pkt,
  output logic                   o_dec_ack,
  output logic                   o_exe_req,
  output rv_pkg::exe_pkt_t       o_exe_pkt,
  input  wire logic              i_exe_ack
);

  rv_pkg::dec_pkt_t        pkt_q;
  rv_pkg::exe_pkt_t        exe_next;
  logic [rv_pkg::XLEN-1:0] alu_res;
  logic [rv_pkg::XLEN-1:0] pc_plus4;
  logic [rv_pkg::XLEN-1:0] pc_target;
  logic                    taken;

  always_comb begin
    case (pkt_q.alu_op)
      rv_pkg::ALU_ADD:  alu_res = pkt_q.op1 + pkt_q.op2;
      rv_pkg::ALU_SUB:  alu_res = pkt_q.op1 - pkt_q.op2;
      rv_pkg::ALU_AND:  alu_res = pkt_q.op1 & pkt_q.op2;
      rv_pkg::ALU_OR:   alu_res = pkt_q.op1 | pkt_q.op2;
      rv_pkg::ALU_XOR:  alu_res = pkt_q.op1 ^ pkt_q.op2;
      rv_pkg::ALU_PASS: alu_res = pkt_q.op2;
      default:          alu_res = '0;
    endcase
  end

  assign pc_plus4  = pkt_q.pc + 64'd4;
  assign pc_target = pkt_q.pc + pkt_q.imm;
  assign taken     = (pkt_q.is_beq && (pkt_q.op1 == pkt_q.op2)) ||
                     (pkt_q.is_bne && (pkt_q.op1 != pkt_q.op2));

  always_comb begin
    exe_next.rd         = pkt_q.rd;
    exe_next.rd_wen     = pkt_q.rd_wen;
    // jal links the return address
    exe_next.result     = pkt_q.is_jal ? pc_plus4 : alu_res;
    exe_next.mem_addr   = pkt_q.op1 + pkt_q.imm;
    exe_next.st_data    = pkt_q.st_data;
    exe_next.is_load    = pkt_q.is_load;
    exe_next.is_store   = pkt_q.is_store;
    exe_next.is_putch   = pkt_q.is_putch;
    exe_next.putch_char = pkt_q.op1[7:0];
    exe_next.next_pc    = (taken || pkt_q.is_jal) ? pc_target : pc_plus4;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_dec_ack <= 1'b0;
      o_exe_req <= 1'b0;
    end else begin
      o_dec_ack <= i_dec_req && !o_dec_ack && !o_exe_req;
      if (o_dec_ack) begin
        o_exe_req <= 1'b1;
      end else if (i_exe_ack) begin
        o_exe_req <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_dec_req && !o_dec_ack && !o_exe_req) begin
      pkt_q <= i_dec_pkt;
    end
    if (o_dec_ack) begin
      o_exe_pkt <= exe_next;
    end
  end

endmodule

`default_nettype wire

/* logic/fetch_stage.sv */
// fetch_stage: holds the pc, reads one instruction per retire and passes it to decode
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
  input  wire logic                     i_clk,
  input  wire logic                     i_rst,
  input  wire logic                     i_retire,
  input  wire logic [rv_pkg::XLEN-1:0]  i_next_pc,
  output logic                          o_ibus_req,
  output logic [rv_pkg::XLEN-1:0]       o_ibus_addr,
  input  wire logic                     i_ibus_ack,
  input  wire logic [rv_pkg::ILEN-1:0]  i_ibus_rdata,
  output logic                          o_fetch_req,
  output rv_pkg::fetch_pkt_t            o_fetch_pkt,
  input  wire logic                     i_fetch_ack
);

  logic [rv_pkg::XLEN-1:0] pc_q;
  // first request after reset
  logic                    boot_q;

  assign o_ibus_addr = pc_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q        <= rv_pkg::RESET_PC;
      boot_q      <= 1'b1;
      o_ibus_req  <= 1'b0;
      o_fetch_req <= 1'b0;
    end else begin
      boot_q <= 1'b0;
      if (boot_q || i_retire) begin
        o_ibus_req <= 1'b1;
      end else if (o_ibus_req && i_ibus_ack) begin
        o_ibus_req <= 1'b0;
      end
      if (i_retire) begin
        pc_q <= i_next_pc;
      end
      if (o_ibus_req && i_ibus_ack) begin
        o_fetch_req <= 1'b1;
      end else if (i_fetch_ack) begin
        o_fetch_req <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_ibus_req && i_ibus_ack) begin
      o_fetch_pkt.pc   <= pc_q;
      o_fetch_pkt.inst <= i_ibus_rdata;
    end
  end

endmodule

`default_nettype wire

/* logic/mem_wb_stage.sv */
// mem_wb_stage: data-bus access, register write-back, putch strobe and retire
`timescale 1ns/1ns
`default_nettype none

module mem_wb_stage (
  input  wire logic                     i_clk,
  input  wire logic                     i_rst,
  input  wire logic                     i_exe_req,
  input  wire rv_pkg::exe_pkt_t         i_exe_pkt,
  output logic                          o_exe_ack,
  output logic                          o_dbus_req,
  output logic                          o_dbus_we,
  output logic [rv_pkg::XLEN-1:0]       o_dbus_addr,
  output logic [rv_pkg::XLEN-1:0]       o_dbus_wdata,
  input  wire logic                     i_dbus_ack,
  input  wire logic [rv_pkg::XLEN-1:0]  i_dbus_rdata,
  output rv_pkg::rf_wr_t                o_rf_wr,
  output logic                          o_retire,
  output logic [rv_pkg::XLEN-1:0]       o_next_pc,
  output logic                          o_putch_valid,
  output logic [7:0]                    o_putch_char
);

  rv_pkg::exe_pkt_t        pkt_q;
  logic                    is_mem;
  logic                    done;
  logic                    wr_en_q;
  logic [rv_pkg::XLEN-1:0] wr_data_q;

  assign is_mem = pkt_q.is_load || pkt_q.is_store;
  // non-memory ops finish right after the take, LD/SD on the bus ack
  assign done   = (o_exe_ack && !is_mem) || (o_dbus_req && i_dbus_ack);

  // held stable from pkt_q while the request is up
  assign o_dbus_we    = pkt_q.is_store;
  assign o_dbus_addr  = pkt_q.mem_addr;
  assign o_dbus_wdata = pkt_q.st_data;
  assign o_next_pc    = pkt_q.next_pc;
  assign o_putch_char = pkt_q.putch_char;
  assign o_rf_wr      = '{idx: pkt_q.rd, en: wr_en_q, data: wr_data_q};

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_exe_ack     <= 1'b0;
      o_dbus_req    <= 1'b0;
      o_retire      <= 1'b0;
      o_putch_valid <= 1'b0;
      wr_en_q       <= 1'b0;
    end else begin
      o_exe_ack <= i_exe_req && !o_exe_ack && !o_dbus_req;
      if (o_exe_ack && is_mem) begin
        o_dbus_req <= 1'b1;
      end else if (i_dbus_ack) begin
        o_dbus_req <= 1'b0;
      end
      o_retire      <= done;
      o_putch_valid <= done && pkt_q.is_putch;
      wr_en_q       <= done && pkt_q.rd_wen;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_exe_req && !o_exe_ack && !o_dbus_req) begin
      pkt_q <= i_exe_pkt;
    end
    if (done) begin
      wr_data_q <= pkt_q.is_load ? i_dbus_rdata : pkt_q.result;
    end
  end

endmodule

`default_nettype wire

/* logic/regfile.sv */
// regfile: 32 x 64 integer registers, two combinational reads, x0 reads zero
`timescale 1ns/1ns
`default_nettype none

module regfile (
  input  wire logic                          i_clk,
  input  wire logic                          i_rst,
  input  wire logic [rv_pkg::REG_IDX_W-1:0]  i_rs1_idx,
  input  wire logic [rv_pkg::REG_IDX_W-1:0]  i_rs2_idx,
  output logic [rv_pkg::XLEN-1:0]            o_rs1_data,
  output logic [rv_pkg::XLEN-1:0]            o_rs2_data,
  input  wire rv_pkg::rf_wr_t                i_wr
);

  logic [rv_pkg::XLEN-1:0] regs [rv_pkg::NUM_REGS];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int k = 0; k < rv_pkg::NUM_REGS; k++) begin
        regs[k] <= '0;
      end
    end else if (i_wr.en && (i_wr.idx != '0)) begin
      regs[i_wr.idx] <= i_wr.data;
    end
  end

  assign o_rs1_data = (i_rs1_idx == '0) ? '0 : regs[i_rs1_idx];
  assign o_rs2_data = (i_rs2_idx == '0) ? '0 : regs[i_rs2_idx];

endmodule

`default_nettype wire

/* logic/rv_core.sv */
// rv_core: single-issue RV64 core, stages linked by req/ack with plain i/d buses
`timescale 1ns/1ns
`default_nettype none

module rv_core (
  input  wire logic                     i_clk,
  input  wire logic                     i_rst,
  // instruction bus
  output logic                          o_ibus_req,
  output logic [rv_pkg::XLEN-1:0]       o_ibus_addr,
  input  wire logic                     i_ibus_ack,
  input  wire logic [rv_pkg::ILEN-1:0]  i_ibus_rdata,
  // data bus
  output logic                          o_dbus_req,
  output logic                          o_dbus_we,
  output logic [rv_pkg::XLEN-1:0]       o_dbus_addr,
  output logic [rv_pkg::XLEN-1:0]       o_dbus_wdata,
  input  wire logic                     i_dbus_ack,
  input  wire logic [rv_pkg::XLEN-1:0]  i_dbus_rdata,
  // character output
  output logic                          o_putch_valid,
  output logic [7:0]                    o_putch_char
);

  // stage handshakes
  logic fetch_req;
  logic fetch_ack;
  logic dec_req;
  logic dec_ack;
  logic exe_req;
  logic exe_ack;
  logic retire;

  rv_pkg::fetch_pkt_t           fetch_pkt;
  rv_pkg::dec_pkt_t             dec_pkt;
  rv_pkg::exe_pkt_t             exe_pkt;
  rv_pkg::rf_wr_t               rf_wr;
  logic [rv_pkg::XLEN-1:0]      next_pc;
  logic [rv_pkg::REG_IDX_W-1:0] rs1_idx;
  logic [rv_pkg::REG_IDX_W-1:0] rs2_idx;
  logic [rv_pkg::XLEN-1:0]      rs1_data;
  logic [rv_pkg::XLEN-1:0]      rs2_data;

  //////////////////////////////////////////////////////////////////////
  // stages

  fetch_stage u_fetch (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_retire     (retire),
    .i_next_pc    (next_pc),
    .o_ibus_req   (o_ibus_req),
    .o_ibus_addr  (o_ibus_addr),
    .i_ibus_ack   (i_ibus_ack),
    .i_ibus_rdata (i_ibus_rdata),
    .o_fetch_req  (fetch_req),
    .o_fetch_pkt  (fetch_pkt),
    .i_fetch_ack  (fetch_ack)
  );

  decode_stage u_decode (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_fetch_req  (fetch_req),
    .i_fetch_pkt  (fetch_pkt),
    .o_fetch_ack  (fetch_ack),
    .o_rs1_idx    (rs1_idx),
    .o_rs2_idx    (rs2_idx),
    .i_rs1_data   (rs1_data),
    .i_rs2_data   (rs2_data),
    .o_dec_req    (dec_req),
    .o_dec_pkt    (dec_pkt),
    .i_dec_ack    (dec_ack)
  );

  execute_stage u_execute (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_dec_req    (dec_req),
    .i_dec_pkt    (dec_pkt),
    .o_dec_ack    (dec_ack),
    .o_exe_req    (exe_req),
    .o_exe_pkt    (exe_pkt),
    .i_exe_ack    (exe_ack)
  );

  mem_wb_stage u_mem_wb (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_exe_req     (exe_req),
    .i_exe_pkt     (exe_pkt),
    .o_exe_ack     (exe_ack),
    .o_dbus_req    (o_dbus_req),
    .o_dbus_we     (o_dbus_we),
    .o_dbus_addr   (o_dbus_addr),
    .o_dbus_wdata  (o_dbus_wdata),
    .i_dbus_ack    (i_dbus_ack),
    .i_dbus_rdata  (i_dbus_rdata),
    .o_rf_wr       (rf_wr),
    .o_retire      (retire),
    .o_next_pc     (next_pc),
    .o_putch_valid (o_putch_valid),
    .o_putch_char  (o_putch_char)
  );

  regfile u_regfile (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rs1_idx  (rs1_idx),
    .i_rs2_idx  (rs2_idx),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_wr       (rf_wr)
  );

endmodule

`default_nettype wire

/* logic/rv_pkg.sv */
// rv_pkg: widths, opcodes, ALU codes and stage packet types for the RV64 core
`default_nettype none

package rv_pkg;

  localparam int XLEN      = 64;
  localparam int ILEN      = 32;
  localparam int REG_IDX_W = 5;
  localparam int NUM_REGS  = 32;

  localparam logic [XLEN-1:0]      RESET_PC   = '0;
  localparam logic [ILEN-1:0]      PUTCH_INST = 32'h0000_007b;
  localparam logic [REG_IDX_W-1:0] PUTCH_REG  = 5'd10;

  // major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // alu operations where PASS forwards op2
  localparam logic [2:0] ALU_ADD  = 3'd0;
  localparam logic [2:0] ALU_SUB  = 3'd1;
  localparam logic [2:0] ALU_AND  = 3'd2;
  localparam logic [2:0] ALU_OR   = 3'd3;
  localparam logic [2:0] ALU_XOR  = 3'd4;
  localparam logic [2:0] ALU_PASS = 3'd5;

  //////////////////////////////////////////////////////////////////////
  // instruction formats

  typedef struct packed {
    logic [6:0]           funct7;
    logic [REG_IDX_W-1:0] rs2;
    logic [REG_IDX_W-1:0] rs1;
    logic [2:0]           funct3;
    logic [REG_IDX_W-1:0] rd;
    logic [6:0]           opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]          imm;
    logic [REG_IDX_W-1:0] rs1;
    logic [2:0]           funct3;
    logic [REG_IDX_W-1:0] rd;
    logic [6:0]           opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]           imm_hi;
    logic [REG_IDX_W-1:0] rs2;
    logic [REG_IDX_W-1:0] rs1;
    logic [2:0]           funct3;
    logic [4:0]           imm_lo;
    logic [6:0]           opcode;
  } s_fmt_t;

  typedef struct packed {
    logic                 imm_12;
    logic [5:0]           imm_10_5;
    logic [REG_IDX_W-1:0] rs2;
    logic [REG_IDX_W-1:0] rs1;
    logic [2:0]           funct3;
    logic [3:0]           imm_4_1;
    logic                 imm_11;
    logic [6:0]           opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0]          imm;
    logic [REG_IDX_W-1:0] rd;
    logic [6:0]           opcode;
  } u_fmt_t;

  typedef struct packed {
    logic                 imm_20;
    logic [9:0]           imm_10_1;
    logic                 imm_11;
    logic [7:0]           imm_19_12;
    logic [REG_IDX_W-1:0] rd;
    logic [6:0]           opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_u;

  //////////////////////////////////////////////////////////////////////
  // stage packets

  typedef struct packed {
    logic [XLEN-1:0] pc;
    inst_u           inst;
  } fetch_pkt_t;

  typedef struct packed {
    logic [XLEN-1:0]      pc;
    logic [XLEN-1:0]      op1;
    logic [XLEN-1:0]      op2;
    logic [XLEN-1:0]      st_data;
    logic [XLEN-1:0]      imm;
    logic [2:0]           alu_op;
    logic [REG_IDX_W-1:0] rd;
    logic                 rd_wen;
    logic                 is_load;
    logic                 is_store;
    logic                 is_beq;
    logic                 is_bne;
    logic                 is_jal;
    logic                 is_putch;
  } dec_pkt_t;

  typedef struct packed {
    logic [REG_IDX_W-1:0] rd;
    logic                 rd_wen;
    logic [XLEN-1:0]      result;
    logic [XLEN-1:0]      mem_addr;
    logic [XLEN-1:0]      st_data;
    logic                 is_load;
    logic                 is_store;
    logic                 is_putch;
    logic [7:0]           putch_char;
    logic [XLEN-1:0]      next_pc;
  } exe_pkt_t;

  typedef struct packed {
    logic [REG_IDX_W-1:0] idx;
    logic                 en;
    logic [XLEN-1:0]      data;
  } rf_wr_t;

endpackage

`default_nettype wire

/* rv_core.f */
logic/rv_pkg.sv
logic/regfile.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mem_wb_stage.sv
logic/rv_core.sv
dv/rv_core_checker.sv
dv/tb_rv_core.sv
